// ==== design/frame_tx_consts.svh ====
`ifndef FRAME_TX_CONSTS_SVH
`define FRAME_TX_CONSTS_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

`define TX_WORD_W      16      // Line word, two octets per clock
`define TX_K_W         2       // One K flag per octet
`define CRC_W          32      // Ethernet FCS
`define RST_EXT_CYCLES 4       // Clocks of reset stretch after arst drops

////////////////////////////////////////
// Octet codes
////////////////////////////////////////

// Idle word halves
`define K28_5     8'hBC        // Comma, low byte of idle
`define D16_2     8'h50        // High byte of idle

// Packet delimiters
`define K27_7     8'hFB        // /S/ start of packet
`define K29_7     8'hFD        // /T/ end of packet
`define K23_7     8'hF7        // /R/ carrier extend

// Frame preamble
`define OCT_PRMBL 8'h55        // Preamble octet
`define OCT_SOF   8'hD5        // Start of frame delimiter

`endif

// ==== design/frame_tx_pkg.sv ====
`include "frame_tx_consts.svh"

package frame_tx_pkg;

	// Sequencer states, one per step of the frame
	typedef enum logic [3:0]
	{
		ST_IDLE,   // Waiting for a request
		ST_SOP,
		ST_PRE1,
		ST_PRE2,
		ST_SOF,    // Acknowledge goes out here
		ST_DATA,   // Payload while valid stays high
		ST_CRC_LO,
		ST_CRC_HI,
		ST_EOP,
		ST_EXT
	} frame_state_e;

	// What the assembler loads into the line register next
	typedef enum logic [3:0]
	{
		WK_IDLE,
		WK_SOP,
		WK_PRE,
		WK_SOF,
		WK_DATA,   // Payload word from the source
		WK_CRC_LO, // FCS bits 15..0
		WK_CRC_HI, // FCS bits 31..16
		WK_EOP,
		WK_EXT
	} word_kind_e;

	// One line word, low byte goes out first
	typedef struct packed
	{
		logic [`TX_K_W-1:0]    charisk; // Bit n flags byte n as a K code
		logic [`TX_WORD_W-1:0] data;
	} tx_word_t;

endpackage

// ==== design/tx_reset_sync.sv ====
`timescale 1ns/100ps
`include "frame_tx_consts.svh"

module tx_reset_sync
(
	input  logic usr_clk_wordwise,
	input  logic arst,             // Async, active high
	output logic rst_o             // Asserts at once, releases on the clock
);

	logic [`RST_EXT_CYCLES-1:0] rst_chain; // Stretch chain

	// Set by arst, zeros walk in from the bottom
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			rst_chain <= '1;
		else
			rst_chain <= {rst_chain[`RST_EXT_CYCLES-2:0], 1'b0};
	end

	assign rst_o = rst_chain[`RST_EXT_CYCLES-1]; // Last stage drives the design

endmodule

// ==== design/frame_sequencer.sv ====
`timescale 1ns/100ps

module frame_sequencer import frame_tx_pkg::*;
(
	input  logic       usr_clk_wordwise,
	input  logic       rst_i,
	input  logic       txd_vld_i,     // Request, then payload valid
	output logic       tx_ack_o,      // One cycle, source starts data on the next edge
	output word_kind_e kind_o,        // Word to load into the line register
	output logic       data_en_o,     // Payload word on txd this cycle
	output logic       crc_clr_o,     // Preset the CRC
	output logic       crc_hi_sel_o   // Upper FCS half to the assembler
);

	frame_state_e state_q;
	frame_state_e state_d;
	word_kind_e   kind_q;
	word_kind_e   kind_d;
	logic         sof_q;       // High for the whole SOF state
	logic         crc_hi_q;

	////////////////////////////////////////
	// Next state and next word kind
	////////////////////////////////////////

	// Head of the frame issues each kind on leaving its state
	// Tail issues each kind on entering its state, so the data exit costs no cycle
	always_comb
	begin
		state_d = state_q;
		kind_d  = WK_IDLE;
		case (state_q)
			ST_IDLE:
			begin
				if (txd_vld_i)
					state_d = ST_SOP; // Request seen
			end
			ST_SOP:
			begin
				state_d = ST_PRE1;
				kind_d  = WK_SOP;
			end
			ST_PRE1:
			begin
				state_d = ST_PRE2;
				kind_d  = WK_PRE;
			end
			ST_PRE2:
			begin
				state_d = ST_SOF;
				kind_d  = WK_PRE;
			end
			ST_SOF:
			begin
				state_d = ST_DATA; // Source answers the ack on this edge
				kind_d  = WK_SOF;
			end
			ST_DATA:
			begin
				if (txd_vld_i)
					kind_d = WK_DATA; // Stay while the source keeps valid up
				else
				begin
					state_d = ST_CRC_LO; // Valid dropped, FCS follows right away
					kind_d  = WK_CRC_LO;
				end
			end
			ST_CRC_LO:
			begin
				state_d = ST_CRC_HI;
				kind_d  = WK_CRC_HI;
			end
			ST_CRC_HI:
			begin
				state_d = ST_EOP;
				kind_d  = WK_EOP;
			end
			ST_EOP:
			begin
				state_d = ST_EXT;
				kind_d  = WK_EXT;
			end
			ST_EXT:
				state_d = ST_IDLE; // At least one idle word before the next SOP
			default:
				state_d = ST_IDLE;
		endcase
	end

	////////////////////////////////////////
	// State, kind and strobe registers
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge rst_i)
	begin
		if (rst_i)
		begin
			state_q  <= ST_IDLE;
			kind_q   <= WK_IDLE;  // Line shows idle out of reset
			sof_q    <= 1'b0;
			crc_hi_q <= 1'b0;
		end
		else
		begin
			state_q  <= state_d;
			kind_q   <= kind_d;
			sof_q    <= (state_d == ST_SOF);
			crc_hi_q <= (state_d == ST_CRC_HI); // Lines up with kind WK_CRC_HI
		end
	end

	assign kind_o       = kind_q;
	assign tx_ack_o     = sof_q;
	assign crc_clr_o    = sof_q;   // CRC preset lands before the first payload edge
	assign crc_hi_sel_o = crc_hi_q;

	// Payload accepted on this edge
	assign data_en_o = (state_q == ST_DATA) && txd_vld_i;

endmodule

// ==== design/crc32_word.sv ====
`timescale 1ns/100ps
`include "frame_tx_consts.svh"

module crc32_word
(
	input  logic                  usr_clk_wordwise,
	input  logic                  rst_i,
	input  logic                  clr_i,     // Preset to all ones
	input  logic                  en_i,      // Advance over d_i
	input  logic [`TX_WORD_W-1:0] d_i,       // Two octets, low byte first
	input  logic                  hi_sel_i,  // 1 selects FCS bits 31..16
	output logic [`TX_WORD_W-1:0] crc_o
);

	// IEEE 802.3 polynomial, reflected form
	localparam logic [`CRC_W-1:0] CRC_POLY_REFL = 32'hEDB88320;

	logic [`CRC_W-1:0] crc_q;
	logic [`CRC_W-1:0] crc_d;
	logic [`CRC_W-1:0] fcs;

	// One octet, LSB first as it goes on the line
	function automatic logic [`CRC_W-1:0] crc_octet
	(
		input logic [`CRC_W-1:0] c,
		input logic [7:0]        b
	);
		logic [`CRC_W-1:0] r;
		r = c;
		for (int i = 0; i < 8; i++)
		begin
			if (r[0] ^ b[i])
				r = (r >> 1) ^ CRC_POLY_REFL;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	// Low octet first, then the high octet
	assign crc_d = crc_octet(crc_octet(crc_q, d_i[7:0]), d_i[15:8]);

	always_ff @(posedge usr_clk_wordwise or posedge rst_i)
	begin
		if (rst_i)
			crc_q <= '1;
		else if (clr_i)
			crc_q <= '1;      // Preset for a new frame
		else if (en_i)
			crc_q <= crc_d;
	end

	// Register already holds the reflected remainder, only the complement is left
	assign fcs   = ~crc_q;
	assign crc_o = hi_sel_i ? fcs[31:16] : fcs[15:0];

endmodule

// ==== design/tx_word_assembler.sv ====
`timescale 1ns/100ps
`include "frame_tx_consts.svh"

module tx_word_assembler import frame_tx_pkg::*;
(
	input  logic                  usr_clk_wordwise,
	input  logic                  rst_i,
	input  word_kind_e            kind_i,    // From the sequencer
	input  logic [`TX_WORD_W-1:0] txd_i,     // Payload from the source
	input  logic [`TX_WORD_W-1:0] crc_i,     // Selected FCS half
	output tx_word_t              tx_word_o  // Line word, valid every cycle
);

	////////////////////////////////////////
	// Symbol table
	////////////////////////////////////////

	localparam tx_word_t IDLE_WORD = '{charisk: 2'b01, data: {`D16_2, `K28_5}};
	localparam tx_word_t SOP_WORD  = '{charisk: 2'b01, data: {`OCT_PRMBL, `K27_7}};
	localparam tx_word_t PRE_WORD  = '{charisk: 2'b00, data: {`OCT_PRMBL, `OCT_PRMBL}};
	localparam tx_word_t SOF_WORD  = '{charisk: 2'b00, data: {`OCT_SOF, `OCT_PRMBL}};
	localparam tx_word_t EOP_WORD  = '{charisk: 2'b11, data: {`K23_7, `K29_7}};
	localparam tx_word_t EXT_WORD  = '{charisk: 2'b11, data: {`K23_7, `K23_7}};

	logic [`TX_WORD_W-1:0] txd_q;    // Payload word accepted on the last edge
	tx_word_t              word_d;
	tx_word_t              word_q;

	// Payload is accepted one edge before its kind reaches us
	always_ff @(posedge usr_clk_wordwise)
	begin
		txd_q <= txd_i;
	end

	// Constant, payload or FCS
	always_comb
	begin
		case (kind_i)
			WK_IDLE:   word_d = IDLE_WORD;
			WK_SOP:    word_d = SOP_WORD;
			WK_PRE:    word_d = PRE_WORD;
			WK_SOF:    word_d = SOF_WORD;
			WK_DATA:   word_d = '{charisk: 2'b00, data: txd_q};
			WK_CRC_LO: word_d = '{charisk: 2'b00, data: crc_i}; // Sequencer picks the half
			WK_CRC_HI: word_d = '{charisk: 2'b00, data: crc_i};
			WK_EOP:    word_d = EOP_WORD;
			WK_EXT:    word_d = EXT_WORD;
			default:   word_d = IDLE_WORD;
		endcase
	end

	////////////////////////////////////////
	// Line output register
	////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge rst_i)
	begin
		if (rst_i)
			word_q <= IDLE_WORD;   // Idle on the line through reset
		else
			word_q <= word_d;
	end

	assign tx_word_o = word_q;

endmodule

// ==== design/frame_tx_top.sv ====
`timescale 1ns/100ps
`include "frame_tx_consts.svh"

module frame_tx_top import frame_tx_pkg::*;
(
	input  logic                  usr_clk_wordwise,
	input  logic                  arst,        // Async reset, active high
	input  logic [`TX_WORD_W-1:0] txd_i,       // Payload word
	input  logic                  txd_vld_i,   // Request and payload valid
	output logic                  tx_ack_o,    // Payload starts on the next edge
	output tx_word_t              tx_word_o    // To the serializer
);

	logic                  rst;         // Stretched internal reset
	word_kind_e            kind;
	logic                  data_en;
	logic                  crc_clr;
	logic                  crc_hi_sel;
	logic [`TX_WORD_W-1:0] crc_word;

	tx_reset_sync i_rst_sync
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.rst_o            (rst)
	);

	// Frame walk and handshake
	frame_sequencer i_seq
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.rst_i            (rst),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.kind_o           (kind),
		.data_en_o        (data_en),
		.crc_clr_o        (crc_clr),
		.crc_hi_sel_o     (crc_hi_sel)
	);

	// FCS over the payload straight from the source
	crc32_word i_crc
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.rst_i            (rst),
		.clr_i            (crc_clr),
		.en_i             (data_en),
		.d_i              (txd_i),
		.hi_sel_i         (crc_hi_sel),
		.crc_o            (crc_word)
	);

	tx_word_assembler i_asm
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.rst_i            (rst),
		.kind_i           (kind),
		.txd_i            (txd_i),
		.crc_i            (crc_word),
		.tx_word_o        (tx_word_o)
	);

endmodule

// ==== verif/frame_tx_ref.svh ====
`ifndef FRAME_TX_REF_SVH
`define FRAME_TX_REF_SVH

////////////////////////////////////////
// Random numbers
////////////////////////////////////////

int unsigned rng_state; // LCG state, seeded by the testbench

// 32-bit LCG, low bits are weak so the top ones are returned
function automatic int unsigned lcg_next();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state >> 8;
endfunction

// Uniform pick in lo..hi
function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
	return lo + (lcg_next() % (hi - lo + 1));
endfunction

////////////////////////////////////////
// Line words
////////////////////////////////////////

function automatic tx_word_t make_word(input logic [1:0] k, input logic [7:0] hi,
	input logic [7:0] lo);
	tx_word_t w;
	w.charisk = k;
	w.data    = {hi, lo}; // Low byte leaves first
	return w;
endfunction

function automatic tx_word_t idle_word();
	return make_word(2'b01, `D16_2, `K28_5);
endfunction

function automatic tx_word_t ext_word();
	return make_word(2'b11, `K23_7, `K23_7);
endfunction

////////////////////////////////////////
// Reference FCS and frame builder
////////////////////////////////////////

// MSB-first CRC over the line bit order, reflected and complemented at the end
function automatic logic [31:0] ref_fcs();
	logic [31:0] c;
	logic [31:0] r;
	logic [7:0]  oct;
	logic        fb;
	c = 32'hFFFFFFFF; // Preset
	foreach (payload[w])
	begin
		for (int h = 0; h < 2; h++)
		begin
			oct = (h == 0) ? payload[w][7:0] : payload[w][15:8]; // Low octet first
			for (int i = 0; i < 8; i++)
			begin
				fb = c[31] ^ oct[i]; // Octet bits go out LSB first
				c  = c << 1;
				if (fb)
					c = c ^ 32'h04C11DB7; // Normal form of the 802.3 polynomial
			end
		end
	end
	for (int i = 0; i < 32; i++)
		r[i] = c[31 - i];
	return ~r;
endfunction

// Appends one whole frame to the expected queue
function automatic void build_expected();
	logic [31:0] fcs;
	fcs = ref_fcs();
	exp_q.push_back(make_word(2'b01, `OCT_PRMBL, `K27_7));     // SOP
	exp_q.push_back(make_word(2'b00, `OCT_PRMBL, `OCT_PRMBL)); // Preamble
	exp_q.push_back(make_word(2'b00, `OCT_PRMBL, `OCT_PRMBL));
	exp_q.push_back(make_word(2'b00, `OCT_SOF, `OCT_PRMBL));   // SOF
	foreach (payload[i])
		exp_q.push_back(make_word(2'b00, payload[i][15:8], payload[i][7:0]));
	exp_q.push_back(make_word(2'b00, fcs[15:8], fcs[7:0]));    // FCS low half
	exp_q.push_back(make_word(2'b00, fcs[31:24], fcs[23:16])); // FCS high half
	exp_q.push_back(make_word(2'b11, `K23_7, `K29_7));         // EOP
	exp_q.push_back(ext_word());
endfunction

`endif

// ==== verif/frame_tx_tb.sv ====
`timescale 1ns/100ps
`include "frame_tx_consts.svh"

module frame_tx_tb import frame_tx_pkg::*;
();

	localparam int  NUM_FRAMES  = 40;
	localparam int  MAX_WORDS   = 16;
	localparam int  MAX_GAP     = 5;
	localparam int  RST_CYCLES  = 16;
	localparam int  ACK_LIMIT   = 40;   // Cycles from request to ack, generous
	localparam int  DRAIN_LIMIT = 60;
	localparam real CLK_PERIOD  = 100.0;
	localparam real WATCHDOG_NS = NUM_FRAMES * 30 * CLK_PERIOD * 2;

	logic                  usr_clk_wordwise = 1'b0;
	logic                  arst;
	logic [`TX_WORD_W-1:0] txd_i;
	logic                  txd_vld_i;
	logic                  tx_ack_o;
	tx_word_t              tx_word_o;

	logic                  ack_wait;   // Source is waiting for its ack
	int                    ack_count;
	tx_word_t              exp_q[$];   // Non-idle words still due on the line
	logic [15:0]           payload[$]; // Current frame

	`include "frame_tx_ref.svh"

	frame_tx_top i_dut
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd_i),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.tx_word_o        (tx_word_o)
	);

	always #(CLK_PERIOD / 2) usr_clk_wordwise = ~usr_clk_wordwise;

	////////////////////////////////////////
	// Error handling
	////////////////////////////////////////

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_error(input string why);
		$display("Error at %0t ns: %s", $time, why);
		abort_run();
	endtask

	task automatic check_equal(input tx_word_t got, input tx_word_t exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s, got k=%b d=%h, expected k=%b d=%h",
				$time, what, got.charisk, got.data, exp.charisk, exp.data);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// Source side
	////////////////////////////////////////

	initial
	begin : stimulus
		int unsigned n_words;
		int unsigned gap;
		int unsigned r;
		int          waited;
		arst      = 1'b0;  // Everything defined from time zero
		txd_i     = '0;
		txd_vld_i = 1'b0;
		ack_wait  = 1'b0;
		ack_count = 0;
		rng_state = 32'd70;
		arst     <= 1'b1;  // Reset edge once all flops wait on it
		repeat (RST_CYCLES) @(posedge usr_clk_wordwise);
		arst <= 1'b0;
		repeat (`RST_EXT_CYCLES + 8) @(posedge usr_clk_wordwise); // Line stays idle here
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			n_words = rand_range(0, MAX_WORDS);
			gap     = rand_range(0, MAX_GAP);
			if (f == 0)
				n_words = 0; // Empty frame always in the mix
			payload.delete();
			for (int j = 0; j < n_words; j++)
			begin
				r = lcg_next();
				payload.push_back(r[15:0]);
			end
			build_expected();
			repeat (gap) @(posedge usr_clk_wordwise);
			txd_vld_i <= 1'b1; // Request level
			ack_wait  <= 1'b1;
			waited = 0;
			do
			begin
				@(posedge usr_clk_wordwise);
				waited++;
				if (waited > ACK_LIMIT)
					report_error($sformatf("no tx_ack_o for frame %0d", f));
			end
			while (!tx_ack_o);
			ack_wait <= 1'b0;
			// First word on the ack edge, one per edge after that
			foreach (payload[j])
			begin
				txd_i <= payload[j];
				@(posedge usr_clk_wordwise);
			end
			txd_vld_i <= 1'b0;
			txd_i     <= '0;
			@(posedge usr_clk_wordwise); // Valid seen low once before the next request
		end
		// Let the last frame leave the line
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge usr_clk_wordwise);
			waited++;
		end
		repeat (4) @(posedge usr_clk_wordwise);
		if (exp_q.size() != 0)
			report_error($sformatf("%0d expected words never came out", exp_q.size()));
		else if (ack_count != NUM_FRAMES)
			report_error($sformatf("saw %0d acks for %0d frames", ack_count, NUM_FRAMES));
		else
		begin
			$display("TEST OK");
			$finish;
		end
	end

	////////////////////////////////////////
	// Line monitor and compare
	////////////////////////////////////////

	initial
	begin : monitor
		tx_word_t w;
		tx_word_t exp;
		logic     after_ext;
		int       frame_no;
		int       word_no;
		after_ext = 1'b0;
		frame_no  = 0;
		word_no   = 0;
		forever
		begin
			@(posedge usr_clk_wordwise);
			w = tx_word_o; // Registered on the previous edge, stable here
			if (tx_ack_o && !ack_wait)
				report_error("tx_ack_o high with no request waiting for it");
			else if (tx_ack_o)
				ack_count++;
			if (after_ext)
				check_equal(w, idle_word(), "idle word after carrier extend");
			after_ext = (w === ext_word());
			if (w !== idle_word())
			begin
				if (exp_q.size() == 0)
					report_error($sformatf("word %h on the line with nothing expected", w));
				else
				begin
					exp = exp_q.pop_front();
					check_equal(w, exp, $sformatf("frame %0d word %0d", frame_no, word_no));
					word_no++;
					if (exp === ext_word())
					begin
						frame_no++; // Carrier extend closes the frame
						word_no = 0;
					end
				end
			end
		end
	end

	// Bounds the run if the DUT stalls
	initial
	begin : watchdog
		#(WATCHDOG_NS);
		report_error("watchdog expired before all frames were sent");
	end

endmodule

// ==== tb.f ====
+incdir+design
+incdir+verif
design/frame_tx_pkg.sv
design/tx_reset_sync.sv
design/frame_sequencer.sv
design/crc32_word.sv
design/tx_word_assembler.sv
design/frame_tx_top.sv
verif/frame_tx_tb.sv

// ==== Bender.yml ====
package:
  name: frame_tx

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/frame_tx_pkg.sv
      - design/tx_reset_sync.sv
      - design/frame_sequencer.sv
      - design/crc32_word.sv
      - design/tx_word_assembler.sv
      - design/frame_tx_top.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/frame_tx_tb.sv
